// ==== tb.f ====
design/hbm_bist_pkg.sv
design/hbm_bist_stats.sv
design/hbm_bist_read_engine.sv
design/hbm_bist_write_engine.sv
design/hbm_bist_top.sv
verif/tb_clk_gen.sv
verif/hbm_axi_slave_model.sv
verif/tb_hbm_bist.sv

// ==== verif/tb_hbm_bist.sv ====
`timescale 1ns/1ns

module tb_hbm_bist;

    import hbm_bist_pkg::*;

    localparam int          PORT_INDEX   = 3;
    localparam int          BEATS        = 16;
    localparam logic [31:0] PATTERN      = 32'ha5a5_a5a5;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          RUN_CYCLES   = 400;
    localparam int          DRAIN_CYCLES = 200;    // Worst case to finish a stalled burst
    localparam int          IDLE_CYCLES  = 8;
    localparam int          PHASES       = 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PHASES * (RUN_CYCLES + DRAIN_CYCLES
                                    + IDLE_CYCLES + 4);
    localparam logic [ADDR_W-1:0] EXP_BASE = ADDR_W'(PORT_INDEX) << 28;

    logic        axi_aclk;
    logic        axi_aresetn;
    logic        start;
    bist_mode_e  mode;
    axi_addr_t   ar;
    axi_addr_t   aw;
    axi_rdata_t  r;
    axi_wdata_t  w;
    logic        arvalid, arready, rvalid, rready;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic [CSR_W-1:0] total_reads, total_writes, read_ticks, write_ticks;
    logic [CSR_W-1:0] exp_reads, exp_writes, exp_rticks, exp_wticks;
    int          w_idx;    // Beat position inside the current W burst
    int          b_owed;   // W bursts still waiting for their B
    int          cycles;

    tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES), .DRIVE_DELAY(DRIVE_DELAY))
        u_clk_gen (.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn));

    hbm_axi_slave_model #(.SEED(32'd7007), .DRIVE_DELAY(DRIVE_DELAY)) u_slave (.*);

    hbm_bist_top #(
        .BIST_NUM     (PORT_INDEX),
        .BURST_BEATS  (BEATS),
        .DATA_PATTERN (PATTERN)
    ) dut (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
            fail_run("Value mismatch");
        end
    endtask

    // Next expected count with clear taking priority
    function automatic logic [CSR_W-1:0] next_count(input logic [CSR_W-1:0] count,
                                                    input logic clr, input logic inc);
        if (clr)
        begin
            return '0;
        end
        return count + CSR_W'(inc);
    endfunction

    // Same 32-bit word in every lane of the beat
    function automatic logic [DATA_W-1:0] pattern_beat(input logic [31:0] pattern);
        logic [DATA_W-1:0] data;
        data = '0;
        for (int i = 0; i < DATA_W / 32; i++)
        begin
            data[i * 32 +: 32] = pattern;
        end
        return data;
    endfunction

    ////////////////////////////////////////////////////////////
    // Monitor and comparison
    ////////////////////////////////////////////////////////////

    always @(negedge axi_aclk)
    begin : monitor
        logic rd_busy;
        logic wr_busy;
        logic rd_clr;
        logic wr_clr;
        if (!axi_aresetn)
        begin
            exp_reads  = '0;
            exp_writes = '0;
            exp_rticks = '0;
            exp_wticks = '0;
            w_idx      = 0;
            b_owed     = 0;
        end
        else
        begin
            check_value("total_reads", total_reads, exp_reads);
            check_value("total_writes", total_writes, exp_writes);
            check_value("read_ticks", read_ticks, exp_rticks);
            check_value("write_ticks", write_ticks, exp_wticks);
            rd_busy = arvalid || rready;
            wr_busy = awvalid || wvalid || bready;
            rd_clr  = !rd_busy && start && (mode == MODE_READ || mode == MODE_BOTH);
            wr_clr  = !wr_busy && start && (mode == MODE_WRITE || mode == MODE_BOTH);
            exp_reads  = next_count(exp_reads, rd_clr, rvalid && rready);
            exp_rticks = next_count(exp_rticks, rd_clr, rd_busy);
            exp_writes = next_count(exp_writes, wr_clr, wvalid && wready);
            exp_wticks = next_count(exp_wticks, wr_clr, wr_busy);
            if (arvalid)
            begin
                check_value("ar.addr", ar.addr, EXP_BASE);
                check_value("ar.len", ar.len, BEATS - 1);
            end
            if (awvalid)
            begin
                check_value("aw.addr", aw.addr, EXP_BASE);
                check_value("aw.len", aw.len, BEATS - 1);
            end
            if (wvalid)
            begin
                check_value("w.data", w.data, pattern_beat(PATTERN));
            end
            if (wvalid && wready)
            begin
                check_value("w.last", w.last, w_idx == BEATS - 1);
                w_idx = (w_idx == BEATS - 1) ? 0 : w_idx + 1;
                if (w.last)
                begin
                    b_owed = b_owed + 1;
                end
            end
            if (bvalid && bready)
            begin
                b_owed = b_owed - 1;
            end
            if (mode == MODE_READ)
            begin
                assert (!wr_busy) else fail_run("Write channel active in read-only mode");
            end
            if (mode == MODE_WRITE)
            begin
                assert (!rd_busy) else fail_run("Read channel active in write-only mode");
            end
        end
    end

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge axi_aclk);
            cycles = cycles + 1;
            assert (cycles <= TIMEOUT_CYCLES)
            else fail_run("Timeout, the engines never returned to idle");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic run_traffic(input bist_mode_e m, input int run_cycles);
        @(posedge axi_aclk);
        #(DRIVE_DELAY);
        mode  = m;
        start = 1'b1;
        repeat (run_cycles) @(posedge axi_aclk);
        #(DRIVE_DELAY);
        start = 1'b0;    // Usually lands mid-burst
        do
        begin
            @(negedge axi_aclk);
        end
        while (arvalid || rready || awvalid || wvalid || bready);
        repeat (IDLE_CYCLES)
        begin
            @(negedge axi_aclk);
            assert (!(arvalid || awvalid)) else fail_run("New burst issued after start dropped");
        end
        assert (b_owed == 0) else fail_run("Write burst ended without taking its response");
        if (m != MODE_WRITE)
        begin
            assert (total_reads != 0 && total_reads % BEATS == 0)
            else fail_run("Read beat count is not a whole number of bursts");
        end
        if (m != MODE_READ)
        begin
            assert (total_writes != 0 && total_writes % BEATS == 0)
            else fail_run("Write beat count is not a whole number of bursts");
        end
    endtask

    initial
    begin
        start = 1'b0;
        mode  = MODE_READ;
        @(posedge axi_aresetn);
        @(negedge axi_aclk);
        assert (!(arvalid || rready || awvalid || wvalid || bready))
        else fail_run("AXI valid or ready high after reset");
        run_traffic(MODE_READ, RUN_CYCLES);
        run_traffic(MODE_WRITE, RUN_CYCLES);
        run_traffic(MODE_BOTH, RUN_CYCLES);
        run_traffic(MODE_BOTH, RUN_CYCLES / 2);    // Restart clears both channels
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== verif/hbm_axi_slave_model.sv ====
`timescale 1ns/1ns

module hbm_axi_slave_model #(
    parameter logic [31:0] SEED        = 32'd7007,
    parameter int          DRIVE_DELAY = 1
) (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,
    input  hbm_bist_pkg::axi_addr_t  ar,
    input  logic                     arvalid,
    output logic                     arready,
    output hbm_bist_pkg::axi_rdata_t r,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic                     awvalid,
    output logic                     awready,
    input  hbm_bist_pkg::axi_wdata_t w,
    input  logic                     wvalid,
    output logic                     wready,
    output logic                     bvalid,
    input  logic                     bready
);

    import hbm_bist_pkg::*;

    logic [31:0]      lcg_state;
    logic [LEN_W-1:0] ar_len;
    logic             rst_done;
    logic             ar_hs;
    logic             r_hs;
    logic             w_last_hs;
    logic             b_hs;
    logic             b_pending;    // Response owed for a finished W burst
    logic             go;
    int               rd_left;      // R beats still to return

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Roughly three cycles in four let a channel move
    task automatic draw_go(output logic ok);
        lcg_state = lcg_next(lcg_state);
        ok = (lcg_state[17:16] != 2'b00);
    endtask

    initial
    begin
        arready   = 1'b0;
        r         = '0;
        rvalid    = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        lcg_state = SEED;
        rd_left   = 0;
        b_pending = 1'b0;
        forever
        begin
            // Handshakes are sampled where everything is settled
            @(negedge axi_aclk);
            rst_done  = axi_aresetn;
            ar_hs     = arvalid && arready;
            ar_len    = ar.len;
            r_hs      = rvalid && rready;
            w_last_hs = wvalid && wready && w.last;
            b_hs      = bvalid && bready;
            @(posedge axi_aclk);
            #(DRIVE_DELAY);
            if (!rst_done)
            begin
                arready   = 1'b0;
                rvalid    = 1'b0;
                awready   = 1'b0;
                wready    = 1'b0;
                bvalid    = 1'b0;
                rd_left   = 0;
                b_pending = 1'b0;
            end
            else
            begin
                if (ar_hs)
                begin
                    rd_left = int'(ar_len) + 1;
                end
                if (r_hs)
                begin
                    rd_left = rd_left - 1;
                end
                if (w_last_hs)
                begin
                    b_pending = 1'b1;
                end
                if (b_hs)
                begin
                    b_pending = 1'b0;
                end
                draw_go(go);
                arready = go && (rd_left == 0);    // One burst at a time
                if (!(rvalid && !r_hs))            // Valid holds until taken
                begin
                    draw_go(go);
                    rvalid = go && (rd_left > 0);
                    r.data = {(DATA_W / 32){lcg_state}};
                    r.last = (rd_left == 1);
                end
                draw_go(go);
                awready = go;
                draw_go(go);
                wready = go;
                if (!(bvalid && !b_hs))
                begin
                    draw_go(go);
                    bvalid = go && b_pending;
                end
            end
        end
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5,
    parameter int DRIVE_DELAY  = 1
) (
    output logic axi_aclk,
    output logic axi_aresetn
);

    initial
    begin
        axi_aclk = 1'b0;
        forever #(PERIOD_NS / 2) axi_aclk = ~axi_aclk;
    end

    // Release just after an edge like all other stimulus
    initial
    begin
        axi_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge axi_aclk);
        #(DRIVE_DELAY);
        axi_aresetn = 1'b1;
    end

endmodule

// ==== design/hbm_bist_top.sv ====
`timescale 1ns/1ns

module hbm_bist_top #(
    parameter int unsigned BIST_NUM     = 0,     // HBM port index
    parameter int unsigned BURST_BEATS  = 16,
    parameter logic [31:0] DATA_PATTERN = 32'ha5a5_a5a5
) (
    input  logic                           axi_aclk,
    input  logic                           axi_aresetn,

    input  logic                           start,
    input  hbm_bist_pkg::bist_mode_e       mode,

    output hbm_bist_pkg::axi_addr_t        ar,
    output logic                           arvalid,
    input  logic                           arready,

    input  hbm_bist_pkg::axi_rdata_t       r,
    input  logic                           rvalid,
    output logic                           rready,

    output hbm_bist_pkg::axi_addr_t        aw,
    output logic                           awvalid,
    input  logic                           awready,

    output hbm_bist_pkg::axi_wdata_t       w,
    output logic                           wvalid,
    input  logic                           wready,

    input  logic                           bvalid,
    output logic                           bready,

    // Statistics registers
    output logic [hbm_bist_pkg::CSR_W-1:0] total_reads,
    output logic [hbm_bist_pkg::CSR_W-1:0] total_writes,
    output logic [hbm_bist_pkg::CSR_W-1:0] read_ticks,
    output logic [hbm_bist_pkg::CSR_W-1:0] write_ticks
);

    import hbm_bist_pkg::*;

    // Each port owns its own region of the stack
    localparam logic [ADDR_W-1:0] BASE_ADDR = ADDR_W'(BIST_NUM) * REGION_BYTES;

    logic rd_clear;
    logic rd_beat;
    logic rd_busy;
    logic wr_clear;
    logic wr_beat;
    logic wr_busy;

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    hbm_bist_read_engine #(
        .BURST_BEATS (BURST_BEATS)
    ) u_read_engine (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .start       (start),
        .mode        (mode),
        .base_addr   (BASE_ADDR),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .clear       (rd_clear),
        .beat        (rd_beat),
        .busy        (rd_busy)
    );

    hbm_bist_stats u_read_stats (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .clear       (rd_clear),
        .beat        (rd_beat),
        .busy        (rd_busy),
        .beats       (total_reads),
        .ticks       (read_ticks)
    );

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    hbm_bist_write_engine #(
        .BURST_BEATS  (BURST_BEATS),
        .DATA_PATTERN (DATA_PATTERN)
    ) u_write_engine (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .start        (start),
        .mode         (mode),
        .base_addr    (BASE_ADDR),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready),
        .clear        (wr_clear),
        .beat         (wr_beat),
        .busy         (wr_busy)
    );

    hbm_bist_stats u_write_stats (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .clear       (wr_clear),
        .beat        (wr_beat),
        .busy        (wr_busy),
        .beats       (total_writes),
        .ticks       (write_ticks)
    );

endmodule

// ==== design/hbm_bist_write_engine.sv ====
`timescale 1ns/1ns

module hbm_bist_write_engine #(
    parameter int unsigned BURST_BEATS  = 16,
    parameter logic [31:0] DATA_PATTERN = 32'ha5a5_a5a5
) (
    input  logic                            axi_aclk,
    input  logic                            axi_aresetn,

    input  logic                            start,
    input  hbm_bist_pkg::bist_mode_e        mode,
    input  logic [hbm_bist_pkg::ADDR_W-1:0] base_addr,

    // Write address channel
    output hbm_bist_pkg::axi_addr_t         aw,
    output logic                            awvalid,
    input  logic                            awready,

    // Write data channel
    output hbm_bist_pkg::axi_wdata_t        w,
    output logic                            wvalid,
    input  logic                            wready,

    // Write response channel
    input  logic                            bvalid,
    output logic                            bready,

    // To statistics
    output logic                            clear,
    output logic                            beat,
    output logic                            busy
);

    import hbm_bist_pkg::*;

    localparam int CNT_W = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,    // awvalid high
        WR_DATA,    // wvalid high
        WR_RESP     // bready high
    } wr_state_e;

    wr_state_e state;
    wr_state_e state_nxt;

    logic             wr_enabled;
    logic             aw_done;
    logic             w_last_done;
    logic             b_done;
    logic [CNT_W-1:0] beat_cnt;    // W beats taken in current burst

    assign wr_enabled = (mode == MODE_WRITE) || (mode == MODE_BOTH);

    ////////////////////////////////////////////////////////////
    // Channel outputs
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        aw.addr = base_addr;
        aw.len  = LEN_W'(BURST_BEATS - 1);
    end

    // Pattern repeated across the whole beat
    always_comb
    begin
        w.data = {(DATA_W / 32){DATA_PATTERN}};
        w.last = (beat_cnt == CNT_W'(BURST_BEATS - 1));
    end

    assign awvalid = (state == WR_ADDR);
    assign wvalid  = (state == WR_DATA);
    assign bready  = (state == WR_RESP);

    assign aw_done     = awvalid && awready;
    assign beat        = wvalid && wready;
    assign w_last_done = beat && w.last;
    assign b_done      = bvalid && bready;

    assign clear = (state == WR_IDLE) && start && wr_enabled;
    assign busy  = (state != WR_IDLE);

    ////////////////////////////////////////////////////////////
    // FSM and beat counter
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            WR_IDLE:
            begin
                if (start && wr_enabled)
                begin
                    state_nxt = WR_ADDR;
                end
            end
            WR_ADDR:
            begin
                if (aw_done)
                begin
                    state_nxt = WR_DATA;
                end
            end
            WR_DATA:
            begin
                if (w_last_done)
                begin
                    state_nxt = WR_RESP;
                end
            end
            WR_RESP:
            begin
                if (b_done)
                begin
                    state_nxt = start ? WR_ADDR : WR_IDLE;    // Stop only on a burst boundary
                end
            end
            default:
            begin
                state_nxt = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (aw_done)
            begin
                beat_cnt <= '0;
            end
            else if (beat)
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    a_w_b_exclusive : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        !(wvalid && bready)
    );

    // Counting from the AW handshake, the final beat is the one carrying last
    a_w_last_final : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        aw_done |=> (wvalid && wready)[->BURST_BEATS] ##0 w.last
    );

endmodule

// ==== design/hbm_bist_read_engine.sv ====
`timescale 1ns/1ns

module hbm_bist_read_engine #(
    parameter int unsigned BURST_BEATS = 16
) (
    input  logic                            axi_aclk,
    input  logic                            axi_aresetn,

    input  logic                            start,
    input  hbm_bist_pkg::bist_mode_e        mode,
    input  logic [hbm_bist_pkg::ADDR_W-1:0] base_addr,

    // Read address channel
    output hbm_bist_pkg::axi_addr_t         ar,
    output logic                            arvalid,
    input  logic                            arready,

    // Read data channel
    input  hbm_bist_pkg::axi_rdata_t        r,
    input  logic                            rvalid,
    output logic                            rready,

    // To statistics
    output logic                            clear,
    output logic                            beat,
    output logic                            busy
);

    import hbm_bist_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,    // arvalid high
        RD_DATA     // rready high
    } rd_state_e;

    rd_state_e state;
    rd_state_e state_nxt;

    logic rd_enabled;
    logic ar_done;
    logic r_last_done;

    assign rd_enabled = (mode == MODE_READ) || (mode == MODE_BOTH);

    ////////////////////////////////////////////////////////////
    // Channel outputs
    ////////////////////////////////////////////////////////////

    // Every burst hits the same port base
    always_comb
    begin
        ar.addr = base_addr;
        ar.len  = LEN_W'(BURST_BEATS - 1);
    end

    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    assign ar_done     = arvalid && arready;
    assign beat        = rvalid && rready;
    assign r_last_done = beat && r.last;

    assign clear = (state == RD_IDLE) && start && rd_enabled;    // New run from idle
    assign busy  = (state != RD_IDLE);

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            RD_IDLE:
            begin
                if (start && rd_enabled)
                begin
                    state_nxt = RD_ADDR;
                end
            end
            RD_ADDR:
            begin
                if (ar_done)
                begin
                    state_nxt = RD_DATA;
                end
            end
            RD_DATA:
            begin
                // Burst always runs to r.last and start only picks what follows
                if (r_last_done)
                begin
                    state_nxt = start ? RD_ADDR : RD_IDLE;
                end
            end
            default:
            begin
                state_nxt = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            state <= RD_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // AR payload must not move while the slave stalls it
    a_ar_stable : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        (arvalid && !arready) |=> arvalid && $stable(ar)
    );

endmodule

// ==== design/hbm_bist_stats.sv ====
`timescale 1ns/1ns

module hbm_bist_stats (
    input  logic                           axi_aclk,
    input  logic                           axi_aresetn,
    input  logic                           clear,    // One cycle pulse from an idle start
    input  logic                           beat,     // One per data handshake
    input  logic                           busy,     // Engine not idle
    output logic [hbm_bist_pkg::CSR_W-1:0] beats,
    output logic [hbm_bist_pkg::CSR_W-1:0] ticks
);

    // Beat counter
    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn || clear)
        begin
            beats <= '0;
        end
        else if (beat)
        begin
            beats <= beats + 1'b1;
        end
    end

    // Busy cycle counter that runs on through back-pressure
    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn || clear)
        begin
            ticks <= '0;
        end
        else if (busy)
        begin
            ticks <= ticks + 1'b1;
        end
    end

endmodule

// ==== design/hbm_bist_pkg.sv ====
package hbm_bist_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W = 33;    // HBM AXI port address
    localparam int DATA_W = 256;   // 32-byte beat
    localparam int LEN_W  = 4;     // AXI3 style burst length
    localparam int CSR_W  = 32;

    // Address stride of 256 MB between pseudo channel ports
    localparam logic [ADDR_W-1:0] REGION_BYTES = ADDR_W'(64'h1000_0000);

    ////////////////////////////////////////////////////////////
    // Traffic opcode
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MODE_READ  = 2'd0,
        MODE_WRITE = 2'd1,
        MODE_BOTH  = 2'd2     // Read and write engines run side by side
    } bist_mode_e;

    ////////////////////////////////////////////////////////////
    // AXI channel payloads
    ////////////////////////////////////////////////////////////

    // AR or AW
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;    // Beats minus one
    } axi_addr_t;

    // W
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_wdata_t;

    // R
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_rdata_t;

endpackage
